/* cfg/cfg_regs.sv */
`timescale 1ns/10ps

module cfg_regs
  import cfg_pkg::*;
#(
  parameter int ucode_addr_width_p = 8,
  parameter int num_cols_p         = 4
)
(
  input  logic                            clk_i,
  input  logic                            reset_i,

  input  mem_msg_s                        cmd_i,
  input  logic                            cmd_v_i,
  output logic                            cmd_yumi_o,

  output mem_msg_s                        resp_o,
  output logic                            resp_v_o,
  input  logic                            resp_yumi_i,

  output cfg_bus_s                        cfg_bus_o,
  input  logic [did_width_gp-1:0]         did_i,
  input  logic [did_width_gp-1:0]         host_did_i,
  input  logic [cord_width_gp-1:0]        cord_i,

  output logic                            ucode_v_o,
  output logic                            ucode_w_o,
  output logic [ucode_addr_width_p-1:0]   ucode_addr_o,
  output logic [ucode_instr_width_gp-1:0] ucode_data_o,
  input  logic [ucode_instr_width_gp-1:0] ucode_data_i
);

  logic                         freeze_r;
  lce_mode_e                    icache_mode_r;
  lce_mode_e                    dcache_mode_r;
  cce_mode_e                    cce_mode_r;
  logic [domain_width_gp-1:0]   domain_mask_r;

  logic                         wr_v;
  logic                         rd_v;
  logic                         ucode_hit;
  logic [cfg_addr_width_gp-1:0] cfg_addr;
  logic [data_width_gp-1:0]     cfg_data;

  logic                         resp_pending_r;
  logic                         first_v;
  logic [3:0]                   read_sel_r;
  logic [3:0]                   read_sel;
  logic [data_width_gp-1:0]     read_mux;
  logic                         held_v_r;
  logic [data_width_gp-1:0]     held_data_r;
  logic [data_width_gp-1:0]     read_data;

  logic [core_id_width_gp-1:0]  core_id;
  logic [cce_id_width_gp-1:0]   cce_id;
  logic [lce_id_width_gp-1:0]   icache_id;
  logic [lce_id_width_gp-1:0]   dcache_id;

  assign wr_v      = cmd_v_i & (cmd_i.header.msg_type == e_mem_uc_wr);
  assign rd_v      = cmd_v_i & (cmd_i.header.msg_type == e_mem_uc_rd);
  assign cfg_addr  = cmd_i.header.addr[cfg_addr_width_gp-1:0];
  assign cfg_data  = cmd_i.data;
  assign ucode_hit = (cfg_addr >= ucode_base_gp);

  // Writes repeat each cycle the command sits at the head.
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      freeze_r      <= 1'b1;
      icache_mode_r <= e_lce_mode_uncached;
      dcache_mode_r <= e_lce_mode_uncached;
      cce_mode_r    <= e_cce_mode_uncached;
      domain_mask_r <= '0;
    end
    else if (wr_v)
    begin
      case (cfg_addr)
        cfg_reg_freeze_gp:      freeze_r      <= cfg_data[0];
        cfg_reg_icache_mode_gp: icache_mode_r <= lce_mode_e'(cfg_data[0]);
        cfg_reg_dcache_mode_gp: dcache_mode_r <= lce_mode_e'(cfg_data[0]);
        cfg_reg_cce_mode_gp:    cce_mode_r    <= cce_mode_e'(cfg_data[0]);
        cfg_reg_domain_mask_gp: domain_mask_r <= cfg_data[domain_width_gp-1:0];
        default: ;
      endcase
    end
  end

  assign ucode_v_o    = (rd_v | wr_v) & ucode_hit;
  assign ucode_w_o    = wr_v & ucode_hit;
  assign ucode_addr_o = cfg_addr[ucode_addr_width_p-1:0];
  assign ucode_data_o = cfg_data[ucode_instr_width_gp-1:0];

  cord_to_id
  #(
    .num_cols_p(num_cols_p)
  )
  id_map
  (
    .cord_i(cord_i),
    .core_id_o(core_id),
    .cce_id_o(cce_id),
    .icache_id_o(icache_id),
    .dcache_id_o(dcache_id)
  );

  assign cfg_bus_o = '{freeze:      freeze_r,
                       core_id:     core_id,
                       icache_id:   icache_id,
                       icache_mode: icache_mode_r,
                       dcache_id:   dcache_id,
                       dcache_mode: dcache_mode_r,
                       cce_id:      cce_id,
                       cce_mode:    cce_mode_r,
                       domain_mask: domain_mask_r};

  assign first_v  = cmd_v_i & ~resp_pending_r;
  assign read_sel = {rd_v & (cfg_addr == cfg_reg_host_did_gp),
                     rd_v & (cfg_addr == cfg_reg_did_gp),
                     rd_v & (cfg_addr == cfg_reg_cord_gp),
                     rd_v & ucode_hit};

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      resp_pending_r <= 1'b0;
      read_sel_r     <= '0;
    end
    else if (resp_yumi_i)
      resp_pending_r <= 1'b0;
    else if (first_v)
    begin
      resp_pending_r <= 1'b1;
      read_sel_r     <= read_sel;
    end
  end

  // One-hot select; all zero for writes and unmapped reads.
  assign read_mux = ({data_width_gp{read_sel_r[3]}} & data_width_gp'(host_did_i))
                  | ({data_width_gp{read_sel_r[2]}} & data_width_gp'(did_i))
                  | ({data_width_gp{read_sel_r[1]}} & data_width_gp'(cord_i))
                  | ({data_width_gp{read_sel_r[0]}} & data_width_gp'(ucode_data_i));

  // Capture one cycle after the select so the RAM output has settled.
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      held_v_r <= 1'b0;
    else if (resp_yumi_i)
      held_v_r <= 1'b0;
    else if (resp_pending_r)
      held_v_r <= 1'b1;
  end

  always_ff @(posedge clk_i)
  begin
    if (resp_pending_r & ~held_v_r)
      held_data_r <= read_mux;
  end

  assign read_data = held_v_r ? held_data_r : read_mux;

  assign resp_o     = '{header: cmd_i.header, data: read_data};
  assign resp_v_o   = resp_pending_r;
  assign cmd_yumi_o = resp_yumi_i; // Buffer pops with the response.

endmodule

/* cfg/cord_to_id.sv */
`timescale 1ns/10ps

module cord_to_id
  import cfg_pkg::*;
#(
  parameter int num_cols_p = 4
)
(
  input  logic [cord_width_gp-1:0]    cord_i,
  output logic [core_id_width_gp-1:0] core_id_o,
  output logic [cce_id_width_gp-1:0]  cce_id_o,
  output logic [lce_id_width_gp-1:0]  icache_id_o,
  output logic [lce_id_width_gp-1:0]  dcache_id_o
);

  localparam int half_width_lp = cord_width_gp / 2;

  logic [half_width_lp-1:0] cord_x;
  logic [half_width_lp-1:0] cord_y;
  logic [15:0]              core_full;

  assign cord_x = cord_i[half_width_lp-1:0];
  assign cord_y = cord_i[cord_width_gp-1:half_width_lp];

  // Row 0 holds no cores, so rows count from y = 1.
  assign core_full = (16'(cord_y) - 16'd1) * 16'(num_cols_p) + 16'(cord_x);

  assign core_id_o   = core_full[core_id_width_gp-1:0];
  assign cce_id_o    = core_full[cce_id_width_gp-1:0];
  assign icache_id_o = {core_id_o, 1'b0};
  assign dcache_id_o = {core_id_o, 1'b1};

endmodule

/* common/cfg_pkg.sv */
package cfg_pkg;

  // Command bus widths.
  localparam int addr_width_gp        = 20;
  localparam int data_width_gp        = 64;
  localparam int cfg_addr_width_gp    = 16;
  localparam int ucode_instr_width_gp = 32;

  // Tile identity widths.
  localparam int did_width_gp     = 4;
  localparam int cord_width_gp    = 6; // {y, x}, 3 bits each.
  localparam int core_id_width_gp = 4;
  localparam int cce_id_width_gp  = 4;
  localparam int lce_id_width_gp  = 5;
  localparam int domain_width_gp  = 3;

  // Start of the microcode window.
  localparam logic [cfg_addr_width_gp-1:0] ucode_base_gp = 16'h8000;

  // Register map.
  localparam logic [cfg_addr_width_gp-1:0] cfg_reg_freeze_gp      = 16'h0002;
  localparam logic [cfg_addr_width_gp-1:0] cfg_reg_icache_mode_gp = 16'h0003;
  localparam logic [cfg_addr_width_gp-1:0] cfg_reg_dcache_mode_gp = 16'h0004;
  localparam logic [cfg_addr_width_gp-1:0] cfg_reg_cce_mode_gp    = 16'h0005;
  localparam logic [cfg_addr_width_gp-1:0] cfg_reg_domain_mask_gp = 16'h0006;
  localparam logic [cfg_addr_width_gp-1:0] cfg_reg_did_gp         = 16'h0008;
  localparam logic [cfg_addr_width_gp-1:0] cfg_reg_host_did_gp    = 16'h0009;
  localparam logic [cfg_addr_width_gp-1:0] cfg_reg_cord_gp        = 16'h000a;

  typedef enum logic [1:0]
  {
    e_mem_wr    = 2'b01,
    e_mem_uc_rd = 2'b10,
    e_mem_uc_wr = 2'b11
  } mem_msg_type_e;

  typedef enum logic [0:0]
  {
    e_lce_mode_uncached = 1'b0,
    e_lce_mode_normal   = 1'b1
  } lce_mode_e;

  typedef enum logic [0:0]
  {
    e_cce_mode_uncached = 1'b0,
    e_cce_mode_normal   = 1'b1
  } cce_mode_e;

  typedef struct packed
  {
    mem_msg_type_e            msg_type;
    logic [addr_width_gp-1:0] addr;
    logic [1:0]               size; // log2 of bytes.
  } mem_header_s;

  typedef struct packed
  {
    mem_header_s              header;
    logic [data_width_gp-1:0] data;
  } mem_msg_s;

  typedef struct packed
  {
    logic                        freeze;
    logic [core_id_width_gp-1:0] core_id;
    logic [lce_id_width_gp-1:0]  icache_id;
    lce_mode_e                   icache_mode;
    logic [lce_id_width_gp-1:0]  dcache_id;
    lce_mode_e                   dcache_mode;
    logic [cce_id_width_gp-1:0]  cce_id;
    cce_mode_e                   cce_mode;
    logic [domain_width_gp-1:0]  domain_mask;
  } cfg_bus_s;

endpackage

/* rtl/cfg_tile.sv */
`timescale 1ns/10ps

module cfg_tile
  import cfg_pkg::*;
#(
  parameter int ucode_addr_width_p = 8,
  parameter int num_cols_p         = 4
)
(
  input  logic                     clk_i,
  input  logic                     reset_i,

  input  mem_msg_s                 mem_cmd_i,
  input  logic                     mem_cmd_v_i,
  output logic                     mem_cmd_ready_o,

  output mem_msg_s                 mem_resp_o,
  output logic                     mem_resp_v_o,
  input  logic                     mem_resp_yumi_i,

  output cfg_bus_s                 cfg_bus_o,
  input  logic [did_width_gp-1:0]  did_i,
  input  logic [did_width_gp-1:0]  host_did_i,
  input  logic [cord_width_gp-1:0] cord_i
);

  mem_msg_s                        fifo_cmd;
  logic                            fifo_cmd_v;
  logic                            fifo_cmd_yumi;

  logic                            ucode_v;
  logic                            ucode_w;
  logic [ucode_addr_width_p-1:0]   ucode_addr;
  logic [ucode_instr_width_gp-1:0] ucode_wdata;
  logic [ucode_instr_width_gp-1:0] ucode_rdata;

  cmd_fifo
  #(
    .width_p($bits(mem_msg_s))
  )
  cmd_buf
  (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .data_i(mem_cmd_i),
    .v_i(mem_cmd_v_i),
    .ready_o(mem_cmd_ready_o),
    .data_o(fifo_cmd),
    .v_o(fifo_cmd_v),
    .yumi_i(fifo_cmd_yumi)
  );

  cfg_regs
  #(
    .ucode_addr_width_p(ucode_addr_width_p),
    .num_cols_p(num_cols_p)
  )
  regs
  (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .cmd_i(fifo_cmd),
    .cmd_v_i(fifo_cmd_v),
    .cmd_yumi_o(fifo_cmd_yumi),
    .resp_o(mem_resp_o),
    .resp_v_o(mem_resp_v_o),
    .resp_yumi_i(mem_resp_yumi_i),
    .cfg_bus_o(cfg_bus_o),
    .did_i(did_i),
    .host_did_i(host_did_i),
    .cord_i(cord_i),
    .ucode_v_o(ucode_v),
    .ucode_w_o(ucode_w),
    .ucode_addr_o(ucode_addr),
    .ucode_data_o(ucode_wdata),
    .ucode_data_i(ucode_rdata)
  );

  ucode_ram
  #(
    .addr_width_p(ucode_addr_width_p)
  )
  ucode_mem
  (
    .clk_i(clk_i),
    .v_i(ucode_v),
    .w_i(ucode_w),
    .addr_i(ucode_addr),
    .data_i(ucode_wdata),
    .rdata_o(ucode_rdata)
  );

endmodule

/* rtl/cmd_fifo.sv */
`timescale 1ns/10ps

module cmd_fifo
#(
  parameter int width_p = 8
)
(
  input  logic               clk_i,
  input  logic               reset_i,

  input  logic [width_p-1:0] data_i,
  input  logic               v_i,
  output logic               ready_o,

  output logic [width_p-1:0] data_o,
  output logic               v_o,
  input  logic               yumi_i
);

  logic               full_r;
  logic [width_p-1:0] data_r;

  assign ready_o = ~full_r;
  assign v_o     = full_r;
  assign data_o  = data_r;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      full_r <= 1'b0;
    else if (v_i & ~full_r)
      full_r <= 1'b1;
    else if (yumi_i)
      full_r <= 1'b0; // Slot frees up, no bypass.
  end

  always_ff @(posedge clk_i)
  begin
    if (v_i & ~full_r)
      data_r <= data_i;
  end

endmodule

/* rtl/ucode_ram.sv */
`timescale 1ns/10ps

module ucode_ram
  import cfg_pkg::*;
#(
  parameter int addr_width_p = 8
)
(
  input  logic                            clk_i,
  input  logic                            v_i,
  input  logic                            w_i,
  input  logic [addr_width_p-1:0]         addr_i,
  input  logic [ucode_instr_width_gp-1:0] data_i,
  output logic [ucode_instr_width_gp-1:0] rdata_o
);

  localparam int depth_lp = 2 ** addr_width_p;

  logic [ucode_instr_width_gp-1:0] mem_r [depth_lp];

  always_ff @(posedge clk_i)
  begin
    if (v_i & w_i)
      mem_r[addr_i] <= data_i;
  end

  // Output holds between reads.
  always_ff @(posedge clk_i)
  begin
    if (v_i & ~w_i)
      rdata_o <= mem_r[addr_i];
  end

endmodule

/* sim/cfg_tile_tb.sv */
`timescale 1ns/10ps

module cfg_tile_tb
  import cfg_pkg::*;
  ();

  localparam int ucode_addr_width_lp = 8;
  localparam int num_cols_lp         = 4;
  localparam int seed_lp             = 32'h93f87b30;
  localparam int num_wr_lp           = 20;
  localparam int num_rd_lp           = 7;
  localparam int num_ucode_lp        = 16;
  localparam int num_stall_lp        = 9;
  localparam int num_cords_lp        = 4;
  localparam int num_cmds_lp = num_wr_lp + num_rd_lp + 2 * num_ucode_lp + num_stall_lp
                               + num_cords_lp;
  localparam int cycle_limit_lp = num_cmds_lp * 12 + 200;

  typedef struct packed
  {
    mem_msg_s resp;
    cfg_bus_s bus;
  } expect_s;

  logic                     clk_i;
  logic                     reset_i;
  mem_msg_s                 mem_cmd_i;
  logic                     mem_cmd_v_i;
  logic                     mem_cmd_ready_o;
  mem_msg_s                 mem_resp_o;
  logic                     mem_resp_v_o;
  logic                     mem_resp_yumi_i;
  cfg_bus_s                 cfg_bus_o;
  logic [did_width_gp-1:0]  did_i;
  logic [did_width_gp-1:0]  host_did_i;
  logic [cord_width_gp-1:0] cord_i;

  // Shadow state of the reference model.
  logic                       freeze_m      = 1'b1;
  lce_mode_e                  icache_mode_m = e_lce_mode_uncached;
  lce_mode_e                  dcache_mode_m = e_lce_mode_uncached;
  cce_mode_e                  cce_mode_m    = e_cce_mode_uncached;
  logic [domain_width_gp-1:0] domain_m      = '0;
  logic [31:0]                ucode_m [2**ucode_addr_width_lp];

  mem_msg_s    exp_q [$];
  cfg_bus_s    exp_bus_r;
  int          error_count = 0;
  int          errs_at_start = 0;
  int          tests_passed = 0;
  int          tests_failed = 0;
  int          cmd_count = 0;
  int          resp_count = 0;
  int          cycle_count = 0;
  int          rand_init;
  logic [19:0] ucode_addrs [num_ucode_lp];
  logic [15:0] reg_addrs [5];

  cfg_tile
  #(
    .ucode_addr_width_p(ucode_addr_width_lp),
    .num_cols_p(num_cols_lp)
  )
  dut_i
  (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .mem_cmd_i(mem_cmd_i),
    .mem_cmd_v_i(mem_cmd_v_i),
    .mem_cmd_ready_o(mem_cmd_ready_o),
    .mem_resp_o(mem_resp_o),
    .mem_resp_v_o(mem_resp_v_o),
    .mem_resp_yumi_i(mem_resp_yumi_i),
    .cfg_bus_o(cfg_bus_o),
    .did_i(did_i),
    .host_did_i(host_did_i),
    .cord_i(cord_i)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  always @(posedge clk_i)
  begin
    cycle_count = cycle_count + 1;
    if (cycle_count > cycle_limit_lp)
    begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit_lp);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  task automatic compare_values(input logic [127:0] actual, input logic [127:0] expected,
                                input string what);
    if (actual !== expected)
    begin
      $display("Fail at %0t ns: %s, got %h expected %h", $time, what, actual, expected);
      error_count = error_count + 1;
    end
  endtask

  function automatic cfg_bus_s expected_bus(input logic [cord_width_gp-1:0] cord);
    cfg_bus_s b;
    int x;
    int y;
    int core;
    x = cord[2:0];
    y = cord[5:3];
    core = ((y - 1) * num_cols_lp + x) & 15; // Ids wrap at 4 bits.
    b.freeze      = freeze_m;
    b.core_id     = core[3:0];
    b.icache_id   = 5'(core * 2);
    b.icache_mode = icache_mode_m;
    b.dcache_id   = 5'(core * 2 + 1);
    b.dcache_mode = dcache_mode_m;
    b.cce_id      = core[3:0];
    b.cce_mode    = cce_mode_m;
    b.domain_mask = domain_m;
    return b;
  endfunction

  function automatic expect_s ref_model(input mem_msg_s cmd, input logic [3:0] did,
                                        input logic [3:0] host_did, input logic [5:0] cord);
    expect_s e;
    logic [15:0] a;
    a = cmd.header.addr[15:0];
    e.resp.header = cmd.header;
    e.resp.data   = '0;
    if (cmd.header.msg_type == e_mem_uc_wr)
    begin
      if (a >= ucode_base_gp)
        ucode_m[a[ucode_addr_width_lp-1:0]] = cmd.data[31:0];
      else if (a == cfg_reg_freeze_gp)
        freeze_m = cmd.data[0];
      else if (a == cfg_reg_icache_mode_gp)
        icache_mode_m = lce_mode_e'(cmd.data[0]);
      else if (a == cfg_reg_dcache_mode_gp)
        dcache_mode_m = lce_mode_e'(cmd.data[0]);
      else if (a == cfg_reg_cce_mode_gp)
        cce_mode_m = cce_mode_e'(cmd.data[0]);
      else if (a == cfg_reg_domain_mask_gp)
        domain_m = cmd.data[domain_width_gp-1:0];
    end
    else if (cmd.header.msg_type == e_mem_uc_rd)
    begin
      if (a >= ucode_base_gp)
        e.resp.data = {32'h0, ucode_m[a[ucode_addr_width_lp-1:0]]};
      else if (a == cfg_reg_did_gp)
        e.resp.data = 64'(did);
      else if (a == cfg_reg_host_did_gp)
        e.resp.data = 64'(host_did);
      else if (a == cfg_reg_cord_gp)
        e.resp.data = 64'(cord);
    end
    e.bus = expected_bus(cord);
    return e;
  endfunction

  // Responses are checked in order as the host takes them.
  always @(posedge clk_i)
  begin
    if (mem_resp_v_o && mem_resp_yumi_i)
    begin
      resp_count = resp_count + 1;
      if (exp_q.size() == 0)
      begin
        $display("Response at %0t ns arrived with no command outstanding", $time);
        error_count = error_count + 1;
      end
      else
        compare_values(mem_resp_o, exp_q.pop_front(), "response");
    end
  end

  task automatic send_cmd(input mem_msg_type_e t, input logic [19:0] addr,
                          input logic [63:0] data);
    mem_msg_s cmd;
    expect_s  e;
    cmd.header.msg_type = t;
    cmd.header.addr     = addr;
    cmd.header.size     = 2'b11;
    cmd.data            = data;
    mem_cmd_i   = cmd;
    mem_cmd_v_i = 1'b1;
    while (!mem_cmd_ready_o)
    begin
      @(posedge clk_i);
      #1;
    end
    @(posedge clk_i);
    #1;
    mem_cmd_v_i = 1'b0;
    e = ref_model(cmd, did_i, host_did_i, cord_i);
    exp_q.push_back(e.resp);
    exp_bus_r = e.bus;
    cmd_count = cmd_count + 1;
  endtask

  task automatic take_resp(input int stall);
    mem_msg_s held;
    while (!mem_resp_v_o)
    begin
      @(posedge clk_i);
      #1;
    end
    held = mem_resp_o;
    repeat (stall)
    begin
      @(posedge clk_i);
      #1;
      compare_values(mem_resp_o, held, "response stable while stalled");
      compare_values(mem_resp_v_o, 1'b1, "response valid while stalled");
      compare_values(mem_cmd_ready_o, 1'b0, "ready low while stalled");
    end
    mem_resp_yumi_i = 1'b1;
    @(posedge clk_i);
    #1;
    mem_resp_yumi_i = 1'b0;
    compare_values(mem_resp_v_o, 1'b0, "valid drops after yumi");
    compare_values(mem_cmd_ready_o, 1'b1, "ready returns after yumi");
    compare_values(cfg_bus_o, exp_bus_r, "cfg_bus after response");
  endtask

  task automatic do_cmd(input mem_msg_type_e t, input logic [19:0] addr,
                        input logic [63:0] data, input int stall);
    send_cmd(t, addr, data);
    take_resp(stall);
  endtask

  task automatic finish_test(input int num, input string name);
    if (error_count == errs_at_start)
    begin
      tests_passed = tests_passed + 1;
      $display("Test %0d %s: ok", num, name);
    end
    else
    begin
      tests_failed = tests_failed + 1;
      $display("Test %0d %s: %0d errors", num, name, error_count - errs_at_start);
    end
    errs_at_start = error_count;
  endtask

  task automatic cord_phase(input logic [5:0] c);
    cord_i = c;
    @(posedge clk_i);
    #1;
    compare_values(cfg_bus_o, expected_bus(cord_i), "ids after cord change");
    do_cmd(e_mem_uc_rd, 20'(cfg_reg_cord_gp), 64'h0, 0);
  endtask

  initial
  begin
    rand_init = $urandom(seed_lp);
    reset_i         = 1'b1;
    mem_cmd_i       = '0;
    mem_cmd_v_i     = 1'b0;
    mem_resp_yumi_i = 1'b0;
    did_i           = 4'(1 + $urandom % 7); // Nonzero and distinct from host_did.
    host_did_i      = 4'(8 + $urandom % 8);
    cord_i          = 6'o12; // y 1, x 2.
    reg_addrs[0] = cfg_reg_freeze_gp;
    reg_addrs[1] = cfg_reg_icache_mode_gp;
    reg_addrs[2] = cfg_reg_dcache_mode_gp;
    reg_addrs[3] = cfg_reg_cce_mode_gp;
    reg_addrs[4] = cfg_reg_domain_mask_gp;
    repeat (10) @(posedge clk_i);
    #1;
    reset_i = 1'b0;

    compare_values(mem_resp_v_o, 1'b0, "response valid after reset");
    compare_values(mem_cmd_ready_o, 1'b1, "ready after reset");
    compare_values(cfg_bus_o, expected_bus(cord_i), "cfg_bus after reset");
    finish_test(1, "reset values");

    for (int i = 0; i < num_wr_lp; i++)
      do_cmd(e_mem_uc_wr, 20'(reg_addrs[i % 5]), {$urandom, $urandom}, 0);
    finish_test(2, "register writes");

    do_cmd(e_mem_uc_rd, 20'(cfg_reg_did_gp), 64'h0, 0);
    do_cmd(e_mem_uc_rd, 20'(cfg_reg_host_did_gp), 64'h0, 0);
    do_cmd(e_mem_uc_rd, 20'(cfg_reg_cord_gp), 64'h0, 0);
    do_cmd(e_mem_uc_rd, 20'h00000, 64'h0, 0);
    do_cmd(e_mem_uc_rd, 20'(cfg_reg_freeze_gp), 64'h0, 0); // Writable regs read as zero.
    do_cmd(e_mem_uc_rd, 20'(cfg_reg_domain_mask_gp), 64'h0, 0);
    do_cmd(e_mem_uc_rd, 20'h07fff, 64'h0, 0);
    finish_test(3, "register reads");

    for (int i = 0; i < num_ucode_lp; i++)
    begin
      ucode_addrs[i] = {4'h0, ucode_base_gp | 16'($urandom % 256)};
      do_cmd(e_mem_uc_wr, ucode_addrs[i], {$urandom, $urandom}, 0);
    end
    for (int i = 0; i < num_ucode_lp; i++)
      do_cmd(e_mem_uc_rd, ucode_addrs[i], 64'h0, 0);
    finish_test(4, "microcode write and read");

    for (int i = 0; i < num_stall_lp; i++)
    begin
      if (i % 3 == 0)
        do_cmd(e_mem_uc_rd, ucode_addrs[i], 64'h0, $urandom % 6);
      else if (i % 3 == 1)
        do_cmd(e_mem_uc_wr, 20'(cfg_reg_domain_mask_gp), {$urandom, $urandom}, $urandom % 6);
      else
        do_cmd(e_mem_uc_rd, 20'(cfg_reg_host_did_gp), 64'h0, $urandom % 6);
    end
    finish_test(5, "back-pressure");

    cord_phase(6'o10);
    cord_phase(6'o33);
    cord_phase(6'o77);
    cord_phase(6'o05); // Row 0 wraps the core id.
    finish_test(6, "cord to id");

    repeat (2) @(posedge clk_i);
    #1;
    if (exp_q.size() != 0 || resp_count != cmd_count)
    begin
      $display("Sent %0d commands but took %0d responses", cmd_count, resp_count);
      error_count = error_count + 1;
    end
    $display("Tests passed: %0d, tests failed: %0d, errors: %0d",
             tests_passed, tests_failed, error_count);
    if (error_count == 0 && tests_failed == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

/* verilog.f */
common/cfg_pkg.sv
rtl/cmd_fifo.sv
cfg/cord_to_id.sv
rtl/ucode_ram.sv
cfg/cfg_regs.sv
rtl/cfg_tile.sv
sim/cfg_tile_tb.sv
